//--- build.f
source/drive_pkg.sv
source/edge_filter.sv
source/quad_counter.sv
source/speed_sampler.sv
source/pwm_bank.sv
source/heartbeat_led.sv
source/drive_top.sv
dv/drive_tb.sv

//--- Bender.yml
package:
  name: drive_feedback

sources:
  - files:
      - source/drive_pkg.sv
      - source/edge_filter.sv
      - source/quad_counter.sv
      - source/speed_sampler.sv
      - source/pwm_bank.sv
      - source/heartbeat_led.sv
      - source/drive_top.sv
  - target: simulation
    files:
      - dv/drive_tb.sv

//--- dv/drive_tb.sv
/* directed testbench for drive_top with short filter, tick and heartbeat lengths
   encoder steps held 10 cycles, outputs sampled on the falling edge */
`timescale 1ns/1ps
`default_nettype none

module drive_tb;
	import drive_pkg::*;

	localparam int unsigned filter_cycles    = 4;
	localparam int unsigned tick_cycles      = 2000;
	localparam int unsigned heartbeat_cycles = 100;
	localparam int unsigned step_hold        = 10;	// cycles per encoder step
	localparam int unsigned max_steps        = 150;	// all steps fit in one window

	logic                   fpga_clk_50;
	logic                   hps_fpga_reset_n;
	logic [motor_count-1:0] enc_a;
	logic [motor_count-1:0] enc_b;
	duty_t                  duty  [motor_count];
	logic [motor_count-1:0] pwm;
	speed_t                 speed [motor_count];
	logic                   speed_valid;
	logic                   led;

	logic [31:0] rng_state;
	int unsigned error_count;
	int unsigned check_count;
	int unsigned test_count;
	int unsigned first_error;	// error count when the test began
	logic [1:0]  phase_idx [motor_count];	// gray position per motor

	drive_top #(.filter_cycles(filter_cycles), .tick_cycles(tick_cycles),
		.heartbeat_cycles(heartbeat_cycles)) UUT
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.enc_a            (enc_a),
		.enc_b            (enc_b),
		.duty             (duty),
		.pwm              (pwm),
		.speed            (speed),
		.speed_valid      (speed_valid),
		.led              (led)
	);

	always #4 fpga_clk_50 = ~fpga_clk_50;	// 125 MHz

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);	// xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// sequence 00 10 11 01 with the pair as A then B
	function automatic logic gray_a(input logic [1:0] idx);
		return (idx == 2'd1) || (idx == 2'd2);
	endfunction

	function automatic logic gray_b(input logic [1:0] idx);
		return (idx == 2'd2) || (idx == 2'd3);
	endfunction

	task automatic check_speed(input string name, input speed_t expected, input speed_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_high_count(input string name, input duty_t expected,
		input logic [$bits(duty_t):0] actual);
		check_count++;
		if (actual !== {1'b0, expected})
		begin
			error_count++;
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR t=%0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_period(input string name, input heartbeat_count_t expected,
		input heartbeat_count_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic abort_run(input string why);
		$display("timeout, %s", why);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, error_count - first_error);
		first_error = error_count;
	endtask

	// catches one speed_valid strobe and returns at the falling clock edge inside it
	task automatic wait_strobe(input string what);
		int unsigned waited;
		waited = 0;
		do
		begin
			@(negedge fpga_clk_50);
			waited++;
		end
		while (speed_valid !== 1'b1 && waited < tick_cycles + 16);
		if (speed_valid !== 1'b1)
			abort_run({"speed_valid never came ", what});
	endtask

	task automatic check_all_zero();
		for (int m = 0; m < motor_count; m++)
			check_speed($sformatf("speed[%0d]", m), 16'sd0, speed[m]);
	endtask

	// ====================
	// tests
	// ====================
	task automatic test_reset_state();
		@(negedge fpga_clk_50);
		for (int m = 0; m < motor_count; m++)
			check_bit($sformatf("pwm[%0d]", m), 1'b0, pwm[m]);
		check_bit("speed_valid", 1'b0, speed_valid);
		check_bit("led", 1'b0, led);
		check_all_zero();
		wait_strobe("after reset");
		check_all_zero();	// first window saw no motion
		report_test("reset_state");
	endtask

	task automatic test_counting();
		int unsigned steps [motor_count];
		int unsigned most;
		logic [motor_count-1:0] next_a;
		logic [motor_count-1:0] next_b;
		speed_t expected;
		most = 0;
		for (int m = 0; m < motor_count; m++)
		begin
			steps[m] = next_random() % max_steps + 1;
			if (steps[m] > most)
				most = steps[m];
		end
		wait_strobe("before stepping");	// window just opened
		for (int i = 0; i < most; i++)
		begin
			for (int m = 0; m < motor_count; m++)
			begin
				if (i < steps[m])
					phase_idx[m] = (m % 2 == 0) ? phase_idx[m] + 2'd1 : phase_idx[m] - 2'd1;
				next_a[m] = gray_a(phase_idx[m]);
				next_b[m] = gray_b(phase_idx[m]);
			end
			@(posedge fpga_clk_50);
			enc_a <= next_a;
			enc_b <= next_b;
			repeat (step_hold - 1) @(posedge fpga_clk_50);
		end
		wait_strobe("after stepping");
		for (int m = 0; m < motor_count; m++)
		begin
			expected = speed_t'(steps[m]);
			if (m % 2 != 0)
				expected = -expected;	// odd motors ran backward
			if (mirror_mask[m])
				expected = -expected;
			check_speed($sformatf("speed[%0d]", m), expected, speed[m]);
		end
		report_test("forward_reverse");
	endtask

	task automatic test_glitch();
		logic [motor_count-1:0] rest_a;
		logic [motor_count-1:0] rest_b;
		wait_strobe("before glitches");
		rest_a = enc_a;
		rest_b = enc_b;
		for (int p = 0; p < 8; p++)
		begin
			// overlapped pulses would walk a whole gray cycle if passed
			@(posedge fpga_clk_50);
			enc_a <= ~rest_a;	// A pulse starts
			@(posedge fpga_clk_50);
			enc_b <= ~rest_b;	// B pulse one cycle later
			@(posedge fpga_clk_50);
			enc_a <= rest_a;	// A held 2 cycles
			@(posedge fpga_clk_50);
			enc_b <= rest_b;
			repeat (step_hold) @(posedge fpga_clk_50);
		end
		wait_strobe("after glitches");
		check_all_zero();
		report_test("glitch_reject");
	endtask

	task automatic test_pwm();
		duty_t               wanted [motor_count];
		logic [$bits(duty_t):0] highs [motor_count];
		for (int m = 0; m < motor_count; m++)
		begin
			wanted[m] = duty_t'(next_random());
			highs[m]  = '0;
		end
		wanted[4] = 8'd0;	// edge cases
		wanted[5] = 8'd255;
		@(posedge fpga_clk_50);
		for (int m = 0; m < motor_count; m++)
			duty[m] <= wanted[m];
		repeat (2 * pwm_period) @(posedge fpga_clk_50);
		repeat (pwm_period)
		begin
			@(negedge fpga_clk_50);
			for (int m = 0; m < motor_count; m++)
				highs[m] = highs[m] + pwm[m];
		end
		for (int m = 0; m < motor_count; m++)
			check_high_count($sformatf("pwm[%0d] high cycles", m), wanted[m], highs[m]);
		report_test("pwm_duty");
	endtask

	task automatic test_heartbeat();
		logic             last_led;
		heartbeat_count_t cycles;
		@(negedge fpga_clk_50);
		last_led = led;
		cycles   = '0;
		while (led === last_led && cycles < 2 * heartbeat_cycles)
		begin
			@(negedge fpga_clk_50);
			cycles++;
		end
		if (led === last_led)
			abort_run("led never toggled");
		last_led = led;
		cycles   = '0;
		while (led === last_led && cycles < 2 * heartbeat_cycles)
		begin
			@(negedge fpga_clk_50);
			cycles++;
		end
		if (led === last_led)
			abort_run("led never toggled a second time");
		check_period("led half period", heartbeat_count_t'(heartbeat_cycles), cycles);
		report_test("heartbeat");
	endtask

	// ====================
	// sequence
	// ====================
	initial
	begin
		fpga_clk_50      = 1'b0;
		hps_fpga_reset_n = 1'b0;
		enc_a            = '0;
		enc_b            = '0;
		for (int m = 0; m < motor_count; m++)
		begin
			duty[m]      = '0;
			phase_idx[m] = 2'd0;	// lines low, matches reset
		end
		rng_state   = 32'h2dd7;
		error_count = 0;
		check_count = 0;
		test_count  = 0;
		first_error = 0;
		repeat (3) @(posedge fpga_clk_50);
		hps_fpga_reset_n <= 1'b1;
		test_reset_state();
		test_counting();
		test_glitch();
		test_pwm();
		test_heartbeat();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/drive_top.sv
/* motor feedback for the six-wheel drive: encoder filter, count and speed
   plus pwm outputs; duty comes from outside, no speed loop is closed here */
`timescale 1ns/1ps
`default_nettype none

module drive_top
#(
	parameter int unsigned filter_cycles    = drive_pkg::default_filter_cycles,
	parameter int unsigned tick_cycles      = drive_pkg::default_tick_cycles,
	parameter int unsigned heartbeat_cycles = drive_pkg::default_heartbeat_cycles
)
(
	input  logic                              fpga_clk_50,
	input  logic                              hps_fpga_reset_n,
	input  logic [drive_pkg::motor_count-1:0] enc_a,	// encoder A per motor
	input  logic [drive_pkg::motor_count-1:0] enc_b,	// encoder B per motor
	input  drive_pkg::duty_t                  duty  [drive_pkg::motor_count],
	output logic [drive_pkg::motor_count-1:0] pwm,
	output drive_pkg::speed_t                 speed [drive_pkg::motor_count],
	output logic                              speed_valid,	// new speeds this cycle
	output logic                              led	// status blink
);
	import drive_pkg::*;

	logic [motor_count-1:0] clean_a;	// filtered encoder lines
	logic [motor_count-1:0] clean_b;
	count_t                 position [motor_count];	// per motor count

	// ==================
	// encoder path
	// ==================
	for (genvar m = 0; m < motor_count; m++)
	begin : g_motor
		edge_filter
		#(
			.filter_cycles    (filter_cycles)
		)
		u_filter_a
		(
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.noisy            (enc_a[m]),
			.clean            (clean_a[m])
		);

		edge_filter
		#(
			.filter_cycles    (filter_cycles)
		)
		u_filter_b
		(
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.noisy            (enc_b[m]),
			.clean            (clean_b[m])
		);

		quad_counter u_counter
		(
			.fpga_clk_50      (fpga_clk_50),
			.hps_fpga_reset_n (hps_fpga_reset_n),
			.phase_a          (clean_a[m]),
			.phase_b          (clean_b[m]),
			.position         (position[m])
		);
	end

	// ==================
	// speed, pwm, led
	// ==================
	speed_sampler
	#(
		.tick_cycles      (tick_cycles)
	)
	u_sampler
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.position         (position),
		.speed            (speed),
		.speed_valid      (speed_valid)
	);

	pwm_bank u_pwm
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.duty             (duty),
		.pwm              (pwm)
	);

	heartbeat_led
	#(
		.heartbeat_cycles (heartbeat_cycles)
	)
	u_heartbeat
	(
		.fpga_clk_50      (fpga_clk_50),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.led              (led)
	);

endmodule

`default_nettype wire

//--- source/heartbeat_led.sv
/* led toggles every heartbeat_cycles, which must fit in heartbeat_count_t */
`timescale 1ns/1ps
`default_nettype none

module heartbeat_led
#(
	parameter int unsigned heartbeat_cycles = drive_pkg::default_heartbeat_cycles
)
(
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	output logic led	// low out of reset
);
	import drive_pkg::*;

	localparam heartbeat_count_t beat_last = heartbeat_count_t'(heartbeat_cycles - 1);

	heartbeat_count_t beat_cnt;

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			beat_cnt <= '0;
			led      <= 1'b0;
		end
		else if (beat_cnt == beat_last)
		begin
			beat_cnt <= '0;
			led      <= ~led;	// half period done
		end
		else
			beat_cnt <= beat_cnt + 1'b1;
	end

endmodule

`default_nettype wire

//--- source/pwm_bank.sv
/* six channels on one 256-cycle period, duty is sampled at the period wrap
   duty 0 is always low and 255 leaves one low cycle per period */
`timescale 1ns/1ps
`default_nettype none

module pwm_bank
(
	input  logic                              fpga_clk_50,
	input  logic                              hps_fpga_reset_n,
	input  drive_pkg::duty_t                  duty [drive_pkg::motor_count],
	output logic [drive_pkg::motor_count-1:0] pwm	// to the motor drivers
);
	import drive_pkg::*;

	localparam duty_t period_last = duty_t'(pwm_period - 1);

	duty_t period_cnt;	// shared by all channels
	duty_t duty_q [motor_count];	// duty in force this period
	logic  period_wrap;

	assign period_wrap = (period_cnt == period_last);

	// ==================
	// period counter
	// ==================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			period_cnt <= '0;
		else if (period_wrap)
			period_cnt <= '0;
		else
			period_cnt <= period_cnt + 1'b1;
	end

	// ==================
	// compare per channel
	// ==================
	// outputs registered so the pins see no compare glitches
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			for (int m = 0; m < motor_count; m++)
				duty_q[m] <= '0;
			pwm <= '0;
		end
		else
		begin
			for (int m = 0; m < motor_count; m++)
			begin
				if (period_wrap)
					duty_q[m] <= duty[m];	// never split a period
				pwm[m] <= (period_cnt < duty_q[m]);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/speed_sampler.sv
/* speed is the position change over one tick window, clipped to speed_t
   right side signs flipped by mirror_mask, tick_cycles must be 2 or more */
`timescale 1ns/1ps
`default_nettype none

module speed_sampler
#(
	parameter int unsigned tick_cycles = drive_pkg::default_tick_cycles
)
(
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  drive_pkg::count_t position [drive_pkg::motor_count],	// live counts
	output drive_pkg::speed_t speed    [drive_pkg::motor_count],	// last window
	output logic              speed_valid	// one cycle, new speeds
);
	import drive_pkg::*;

	localparam int unsigned tick_w = $clog2(tick_cycles);
	localparam logic [tick_w-1:0] tick_last = tick_w'(tick_cycles - 1);

	// clip limits, widened to the difference width
	localparam logic signed [33:0] speed_max = 34'sd32767;
	localparam logic signed [33:0] speed_min = -34'sd32768;

	logic [tick_w-1:0] tick_cnt;	// window counter shared by all motors
	logic              tick;
	count_t            prev_pos [motor_count];	// position at the last tick
	logic signed [33:0] delta   [motor_count];	// signed change, mirror applied

	// saturate a wide difference into speed_t
	function automatic speed_t sat_speed(input logic signed [33:0] value);
		speed_t result;
		if (value > speed_max)
			result = 16'sh7fff;
		else if (value < speed_min)
			result = 16'sh8000;
		else
			result = speed_t'(value);	// in range, plain truncate
		return result;
	endfunction

	// ==================
	// window tick
	// ==================
	assign tick = (tick_cnt == tick_last);

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// ==================
	// difference
	// ==================
	// 33 bits hold any 32-bit difference, one more for the negate
	always_comb
	begin
		for (int m = 0; m < motor_count; m++)
		begin
			delta[m] = $signed({{2{position[m][31]}}, position[m]})
				- $signed({{2{prev_pos[m][31]}}, prev_pos[m]});
			if (mirror_mask[m])
				delta[m] = -delta[m];	// mirrored mount
		end
	end

	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			for (int m = 0; m < motor_count; m++)
			begin
				prev_pos[m] <= '0;
				speed[m]    <= '0;
			end
			speed_valid <= 1'b0;
		end
		else
		begin
			speed_valid <= tick;	// high with the new speeds
			if (tick)
			begin
				for (int m = 0; m < motor_count; m++)
				begin
					prev_pos[m] <= position[m];
					speed[m]    <= sat_speed(delta[m]);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/quad_counter.sv
/* four-edge quadrature decode of filtered lines, A leading B counts up
   a step that moves both lines at once is dropped, the count wraps silently */
`timescale 1ns/1ps
`default_nettype none

module quad_counter
(
	input  logic              fpga_clk_50,
	input  logic              hps_fpga_reset_n,
	input  logic              phase_a,	// clean A line
	input  logic              phase_b,	// clean B line
	output drive_pkg::count_t position	// signed running count
);

	typedef enum logic [1:0]
	{
		step_none,
		step_fwd,
		step_rev
	} step_t;

	logic  prev_a;	// pair seen last cycle
	logic  prev_b;
	step_t step;

	// ==================
	// step decode
	// ==================
	// pair written as {a, b}
	// forward walks 00 -> 10 -> 11 -> 01 -> 00
	always_comb
	begin
		case ({prev_a, prev_b, phase_a, phase_b})
			4'b00_10,
			4'b10_11,
			4'b11_01,
			4'b01_00:
				step = step_fwd;
			4'b00_01,
			4'b01_11,
			4'b11_10,
			4'b10_00:
				step = step_rev;
			default:
				step = step_none;	// no change, or an illegal double step
		endcase
	end

	// ==================
	// count
	// ==================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			prev_a   <= 1'b0;	// filters also leave reset low
			prev_b   <= 1'b0;
			position <= '0;
		end
		else
		begin
			prev_a <= phase_a;
			prev_b <= phase_b;
			case (step)
				step_fwd:
					position <= position + 32'sd1;
				step_rev:
					position <= position - 32'sd1;
				default:
					position <= position;	// hold
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/edge_filter.sv
/* one encoder line in, async to fpga_clk_50; filter_cycles must be 1 or more
   and fit in filter_count_t, pulses shorter than that never reach clean */
`timescale 1ns/1ps
`default_nettype none

module edge_filter
#(
	parameter int unsigned filter_cycles = drive_pkg::default_filter_cycles
)
(
	input  logic fpga_clk_50,
	input  logic hps_fpga_reset_n,
	input  logic noisy,	// raw encoder line from the connector
	output logic clean	// filtered level
);
	import drive_pkg::*;

	// last count value before a new level is accepted
	localparam filter_count_t hold_last = filter_count_t'(filter_cycles - 1);

	logic sync_1;	// first stage, may go metastable
	logic sync_2;	// safe to use from here on
	filter_count_t hold_cnt;	// cycles the new level has held so far

	// ==================
	// synchronizer
	// ==================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end
		else
		begin
			sync_1 <= noisy;
			sync_2 <= sync_1;
		end
	end

	// ==================
	// stability counter
	// ==================
	always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
	begin
		if (!hps_fpga_reset_n)
		begin
			hold_cnt <= '0;
			clean    <= 1'b0;
		end
		else if (sync_2 == clean)
			hold_cnt <= '0;	// same as output, nothing pending
		else if (hold_cnt == hold_last)
		begin
			clean    <= sync_2;	// held long enough, accept
			hold_cnt <= '0;
		end
		else
			hold_cnt <= hold_cnt + 1'b1;
	end

endmodule

`default_nettype wire

//--- source/drive_pkg.sv
/* shared widths and default timing for the six-motor feedback path
   defaults assume a 50 MHz fpga_clk_50 */
`default_nettype none

package drive_pkg;

	// ==================
	// motor set
	// ==================
	localparam int unsigned motor_count = 6;	// six wheels, index 0 to 5

	// right side motors are mounted mirrored
	// so a forward roll counts down on them
	localparam logic [motor_count-1:0] mirror_mask = 6'b111000;

	// ==================
	// data types
	// ==================
	typedef logic signed [31:0] count_t;	// encoder position, four edges per line
	typedef logic signed [15:0] speed_t;	// counts per sample window, saturated
	typedef logic [7:0] duty_t;	// high cycles per pwm period

	// pwm period follows the duty width
	localparam int unsigned pwm_period = 2 ** $bits(duty_t);	// 256 cycles

	// ==================
	// timing defaults
	// ==================
	// encoder glitch filter
	typedef logic [15:0] filter_count_t;
	localparam int unsigned default_filter_cycles = 50;	// 1 us at 50 MHz

	// speed sample window
	localparam int unsigned default_tick_cycles = 250000;	// 5 ms at 50 MHz

	// status led
	typedef logic [25:0] heartbeat_count_t;
	localparam int unsigned default_heartbeat_cycles = 25000000;	// 0.5 s per toggle

endpackage

`default_nettype wire
